// ==== rtl/xfcp_defs.svh ====
// Command hub sizing
// Port count and bus widths shared by the RTL and the testbench
`ifndef XFCP_DEFS_SVH
`define XFCP_DEFS_SVH

// RAM endpoints behind the router
`define XFCP_NUM_PORTS 3

// Endpoint word address width
`define XFCP_ADDR_W 8

`define XFCP_DATA_W 32
`define XFCP_BYTE_W 8

`endif

// ==== rtl/xfcp_proto_pkg.sv ====
// Command hub packet types
// Opcodes and the 4-byte header, which the router fills byte by byte and
// reads back as fields, and which the endpoints send out as bytes
`default_nettype none

`include "xfcp_defs.svh"

package xfcp_proto_pkg;

    typedef logic [`XFCP_BYTE_W-1:0] byte_t;

    typedef enum logic [7:0] {
        READ_REQ   = 8'h10,
        READ_RESP  = 8'h11,
        WRITE_REQ  = 8'h12,
        WRITE_RESP = 8'h13
    } opcode_e;

    // Port is the first byte on the wire
    typedef struct packed {
        byte_t   port;
        opcode_e opcode;
        byte_t   addr;
        byte_t   count;
    } hdr_fields_t;

    // Octet 0 lines up with port
    typedef union packed {
        hdr_fields_t     fields;
        byte_t [0:3]     octets;
    } hdr_u;

endpackage

`default_nettype wire

// ==== rtl/xfcp_mem_pkg.sv ====
// Endpoint memory types
// One RAM word and one word address
`default_nettype none

`include "xfcp_defs.svh"

package xfcp_mem_pkg;

    typedef logic [`XFCP_DATA_W-1:0] word_t;

    typedef logic [`XFCP_ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== rtl/xfcp_cmd_router.sv ====
// Command router
// Gathers the 4-byte request header, hands it to the endpoint named by
// the port byte, then forwards the payload there up to last.
// Packets for a port that does not exist are drained and dropped.
`timescale 1ns/1ps
`default_nettype none

`include "xfcp_defs.svh"

module xfcp_cmd_router (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire xfcp_proto_pkg::byte_t   in_data_i,
    input  wire                          in_valid_i,
    input  wire                          in_last_i,
    output logic                         in_ready_o,
    output xfcp_proto_pkg::hdr_u         ep_hdr_o [`XFCP_NUM_PORTS],
    output logic [`XFCP_NUM_PORTS-1:0]   ep_hdr_valid_o,
    input  wire  [`XFCP_NUM_PORTS-1:0]   ep_hdr_ready_i,
    output xfcp_proto_pkg::byte_t        ep_data_o,
    output logic [`XFCP_NUM_PORTS-1:0]   ep_valid_o,
    output logic                         ep_last_o,
    input  wire  [`XFCP_NUM_PORTS-1:0]   ep_ready_i
);

    localparam int N = `XFCP_NUM_PORTS;

    typedef enum logic [1:0] {R_HDR, R_HAND, R_FWD, R_DROP} state_e;

    state_e                state;
    logic [1:0]            idx;
    logic                  hdr_last;
    xfcp_proto_pkg::hdr_u  hdr_q;
    logic [N-1:0]          sel_oh;
    logic                  in_xfer;

    assign sel_oh    = N'(1) << hdr_q.fields.port;
    assign in_xfer   = in_valid_i && in_ready_o;
    assign ep_data_o = in_data_i;

    // During handover, last tells the endpoint the packet ended with the header
    always_comb begin
        in_ready_o     = 1'b0;
        ep_hdr_valid_o = '0;
        ep_valid_o     = '0;
        ep_last_o      = in_last_i;
        case (state)
            // No byte is taken while in reset
            R_HDR, R_DROP: in_ready_o = !rst_i;
            R_HAND: begin
                ep_hdr_valid_o = sel_oh;
                ep_last_o      = hdr_last;
            end
            R_FWD: begin
                in_ready_o = |(ep_ready_i & sel_oh);
                ep_valid_o = in_valid_i ? sel_oh : '0;
            end
            default: ;
        endcase
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            ep_hdr_o[i] = hdr_q;
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_HDR && in_valid_i) begin
            hdr_q.octets[idx] <= in_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state    <= R_HDR;
            idx      <= '0;
            hdr_last <= 1'b0;
        end else begin
            case (state)
                R_HDR: begin
                    if (in_valid_i) begin
                        // Runt packets just restart the header
                        idx <= in_last_i ? 2'd0 : idx + 2'd1;
                        if (idx == 2'd3) begin
                            hdr_last <= in_last_i;
                            if (hdr_q.fields.port < N) begin
                                state <= R_HAND;
                            end else if (!in_last_i) begin
                                state <= R_DROP;
                            end
                        end
                    end
                end
                R_HAND: begin
                    if (|(ep_hdr_ready_i & sel_oh)) begin
                        state <= hdr_last ? R_HDR : R_FWD;
                    end
                end
                R_FWD, R_DROP: begin
                    if (in_xfer && in_last_i) begin
                        state <= R_HDR;
                    end
                end
                default: state <= R_HDR;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xfcp_ram_endpoint.sv ====
// RAM endpoint
// Runs read and write requests against a local word RAM and answers
// with a response packet. Words travel least significant byte first and
// addresses wrap at the RAM size. Unknown opcodes are drained silently.
`timescale 1ns/1ps
`default_nettype none

`include "xfcp_defs.svh"

module xfcp_ram_endpoint (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire xfcp_proto_pkg::hdr_u    hdr_i,
    input  wire                          hdr_valid_i,
    output logic                         hdr_ready_o,
    input  wire xfcp_proto_pkg::byte_t   data_i,
    input  wire                          valid_i,
    input  wire                          last_i,
    output logic                         ready_o,
    output xfcp_proto_pkg::byte_t        rsp_data_o,
    output logic                         rsp_valid_o,
    output logic                         rsp_last_o,
    input  wire                          rsp_ready_i
);

    localparam int WBUF_W = `XFCP_DATA_W - `XFCP_BYTE_W;
    localparam xfcp_proto_pkg::byte_t ONE = 1;

    typedef enum logic [2:0] {S_IDLE, S_WRITE, S_DRAIN, S_RSP_HDR, S_RSP_DATA} state_e;

    state_e                 state;
    xfcp_proto_pkg::hdr_u   hdr_q;
    xfcp_proto_pkg::hdr_u   rsp_hdr;
    xfcp_proto_pkg::byte_t  cnt;
    logic [1:0]             bidx;
    xfcp_mem_pkg::addr_t    addr;
    xfcp_mem_pkg::addr_t    rd_addr;
    logic [WBUF_W-1:0]      wbuf;
    xfcp_mem_pkg::word_t    mem [0:(1 << `XFCP_ADDR_W)-1];
    xfcp_mem_pkg::word_t    rd_word;
    logic                   rd_en;
    logic                   wr_en;
    logic                   is_read;
    logic                   in_xfer;
    logic                   rsp_xfer;

    assign is_read  = (hdr_q.fields.opcode == xfcp_proto_pkg::READ_REQ);
    assign in_xfer  = valid_i && ready_o;
    assign rsp_xfer = rsp_valid_o && rsp_ready_i;

    always_comb begin
        rsp_hdr = hdr_q;
        rsp_hdr.fields.opcode = is_read ? xfcp_proto_pkg::READ_RESP
                                        : xfcp_proto_pkg::WRITE_RESP;
    end

    assign hdr_ready_o = (state == S_IDLE);
    assign ready_o     = (state == S_WRITE) || (state == S_DRAIN);
    assign rsp_valid_o = (state == S_RSP_HDR) || (state == S_RSP_DATA);
    assign rsp_data_o  = (state == S_RSP_DATA) ? rd_word[`XFCP_BYTE_W*bidx +: `XFCP_BYTE_W]
                                               : rsp_hdr.octets[bidx];
    assign rsp_last_o  = (bidx == 2'd3) &&
                         (((state == S_RSP_HDR) && !is_read) ||
                          ((state == S_RSP_DATA) && (cnt == ONE)));

    // Fetch the next word while the current one is still going out
    assign rd_en   = (state == S_RSP_HDR) ||
                     ((state == S_RSP_DATA) && rsp_xfer && (bidx == 2'd3));
    assign rd_addr = (state == S_RSP_HDR) ? addr : addr + 1'b1;
    assign wr_en   = (state == S_WRITE) && in_xfer && (cnt != '0) && (bidx == 2'd3);

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
        if (wr_en) begin
            mem[addr] <= {data_i, wbuf};
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_ready_o && hdr_valid_i) begin
            hdr_q <= hdr_i;
            addr  <= xfcp_mem_pkg::addr_t'(hdr_i.fields.addr);
            // Zero count means one word
            cnt   <= (hdr_i.fields.count == '0) ? ONE : hdr_i.fields.count;
        end
        if (state == S_WRITE && in_xfer) begin
            wbuf <= {data_i, wbuf[WBUF_W-1:`XFCP_BYTE_W]};
        end
        if (wr_en || (rd_en && state == S_RSP_DATA)) begin
            addr <= addr + 1'b1;
            cnt  <= cnt - ONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= S_IDLE;
            bidx  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    bidx <= '0;
                    // last_i high here means no payload follows the header
                    if (hdr_valid_i) begin
                        case (hdr_i.fields.opcode)
                            xfcp_proto_pkg::READ_REQ:  state <= last_i ? S_RSP_HDR : S_DRAIN;
                            xfcp_proto_pkg::WRITE_REQ: state <= last_i ? S_RSP_HDR : S_WRITE;
                            default:                   state <= last_i ? S_IDLE : S_DRAIN;
                        endcase
                    end
                end
                S_WRITE: begin
                    if (in_xfer) begin
                        bidx <= bidx + 2'd1;
                        if (last_i) begin
                            bidx  <= '0;
                            state <= S_RSP_HDR;
                        end
                    end
                end
                S_DRAIN: begin
                    if (in_xfer && last_i) begin
                        state <= is_read ? S_RSP_HDR : S_IDLE;
                    end
                end
                S_RSP_HDR: begin
                    if (rsp_xfer) begin
                        bidx <= bidx + 2'd1;
                        if (bidx == 2'd3) begin
                            state <= is_read ? S_RSP_DATA : S_IDLE;
                        end
                    end
                end
                S_RSP_DATA: begin
                    if (rsp_xfer) begin
                        bidx <= bidx + 2'd1;
                        if (bidx == 2'd3 && cnt == ONE) begin
                            state <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xfcp_resp_arbiter.sv ====
// Response arbiter
// Round-robin merge of the endpoint response streams into one output.
// The granted endpoint is passed through with no register stage and
// keeps the grant until its last byte has gone out.
`timescale 1ns/1ps
`default_nettype none

`include "xfcp_defs.svh"

module xfcp_resp_arbiter (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire xfcp_proto_pkg::byte_t   rsp_data_i [`XFCP_NUM_PORTS],
    input  wire  [`XFCP_NUM_PORTS-1:0]   rsp_valid_i,
    input  wire  [`XFCP_NUM_PORTS-1:0]   rsp_last_i,
    output logic [`XFCP_NUM_PORTS-1:0]   rsp_ready_o,
    output xfcp_proto_pkg::byte_t        out_data_o,
    output logic                         out_valid_o,
    output logic                         out_last_o,
    input  wire                          out_ready_i
);

    localparam int N     = `XFCP_NUM_PORTS;
    localparam int SEL_W = (N > 1) ? $clog2(N) : 1;

    logic             locked;
    logic [SEL_W-1:0] grant;
    logic [SEL_W-1:0] last_win;
    logic [SEL_W-1:0] pick;
    logic [SEL_W-1:0] sel;

    // Nearest valid port after the previous winner wins
    always_comb begin
        int cand;
        pick = last_win;
        for (int i = N; i >= 1; i--) begin
            cand = (int'(last_win) + i) % N;
            if (rsp_valid_i[cand]) begin
                pick = SEL_W'(cand);
            end
        end
    end

    assign sel         = locked ? grant : pick;
    assign out_valid_o = rsp_valid_i[sel];
    assign out_data_o  = rsp_data_i[sel];
    assign out_last_o  = rsp_last_i[sel];

    always_comb begin
        rsp_ready_o      = '0;
        rsp_ready_o[sel] = out_ready_i;
    end

    // Lock as soon as a byte is offered so a stalled output stays stable
    always_ff @(posedge clk) begin
        if (rst_i) begin
            locked   <= 1'b0;
            grant    <= '0;
            last_win <= SEL_W'(N - 1);
        end else if (out_valid_o) begin
            grant <= sel;
            if (out_ready_i && out_last_o) begin
                locked   <= 1'b0;
                last_win <= sel;
            end else begin
                locked <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xfcp_ram_hub.sv ====
// Command hub top level
// Request stream in, router to the RAM endpoints, arbiter back out
`timescale 1ns/1ps
`default_nettype none

`include "xfcp_defs.svh"

module xfcp_ram_hub (
    input  wire                          clk,
    input  wire                          rst_i,
    input  wire xfcp_proto_pkg::byte_t   in_data_i,
    input  wire                          in_valid_i,
    input  wire                          in_last_i,
    output logic                         in_ready_o,
    output xfcp_proto_pkg::byte_t        out_data_o,
    output logic                         out_valid_o,
    output logic                         out_last_o,
    input  wire                          out_ready_i
);

    localparam int N = `XFCP_NUM_PORTS;

    wire xfcp_proto_pkg::hdr_u   ep_hdr [N];
    wire [N-1:0]                 ep_hdr_valid;
    wire [N-1:0]                 ep_hdr_ready;
    wire xfcp_proto_pkg::byte_t  ep_data;
    wire [N-1:0]                 ep_valid;
    wire                         ep_last;
    wire [N-1:0]                 ep_ready;

    wire xfcp_proto_pkg::byte_t  rsp_data [N];
    wire [N-1:0]                 rsp_valid;
    wire [N-1:0]                 rsp_last;
    wire [N-1:0]                 rsp_ready;

    xfcp_cmd_router router_inst (
        .clk(clk),
        .rst_i(rst_i),
        .in_data_i(in_data_i),
        .in_valid_i(in_valid_i),
        .in_last_i(in_last_i),
        .in_ready_o(in_ready_o),
        .ep_hdr_o(ep_hdr),
        .ep_hdr_valid_o(ep_hdr_valid),
        .ep_hdr_ready_i(ep_hdr_ready),
        .ep_data_o(ep_data),
        .ep_valid_o(ep_valid),
        .ep_last_o(ep_last),
        .ep_ready_i(ep_ready)
    );

    for (genvar g = 0; g < N; g++) begin : g_ep
        xfcp_ram_endpoint ram_inst (
            .clk(clk),
            .rst_i(rst_i),
            .hdr_i(ep_hdr[g]),
            .hdr_valid_i(ep_hdr_valid[g]),
            .hdr_ready_o(ep_hdr_ready[g]),
            .data_i(ep_data),
            .valid_i(ep_valid[g]),
            .last_i(ep_last),
            .ready_o(ep_ready[g]),
            .rsp_data_o(rsp_data[g]),
            .rsp_valid_o(rsp_valid[g]),
            .rsp_last_o(rsp_last[g]),
            .rsp_ready_i(rsp_ready[g])
        );
    end

    xfcp_resp_arbiter arbiter_inst (
        .clk(clk),
        .rst_i(rst_i),
        .rsp_data_i(rsp_data),
        .rsp_valid_i(rsp_valid),
        .rsp_last_i(rsp_last),
        .rsp_ready_o(rsp_ready),
        .out_data_o(out_data_o),
        .out_valid_o(out_valid_o),
        .out_last_o(out_last_o),
        .out_ready_i(out_ready_i)
    );

endmodule

`default_nettype wire

// ==== verif/xfcp_ram_hub_assertions.sv ====
// Command hub stream protocol checks
// Reset behavior of both streams and stability of a stalled response byte
`timescale 1ns/1ps
`default_nettype none

module xfcp_ram_hub_assertions (
    input wire       clk,
    input wire       rst_i,
    input wire       in_valid_i,
    input wire       in_ready_o,
    input wire [7:0] out_data_o,
    input wire       out_valid_o,
    input wire       out_last_o,
    input wire       out_ready_i
);

    out_idle_in_reset: assert property (@(posedge clk) rst_i |-> !out_valid_o)
        else $error("response valid high during reset");

    // Stalled byte stays on the bus unchanged
    out_hold_on_stall: assert property (@(posedge clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_last_o))
        else $error("response byte changed while stalled");

    in_no_accept_in_reset: assert property (@(posedge clk) rst_i |-> !(in_valid_i && in_ready_o))
        else $error("request byte accepted during reset");

endmodule

`default_nettype wire

// ==== verif/xfcp_ram_hub_tb.sv ====
// Command hub testbench
// Random requests against a per-port memory model. Expected responses wait
// in one queue per port and are matched by the echoed port byte.
`timescale 1ns/1ps
`default_nettype none

`include "xfcp_defs.svh"

module xfcp_ram_hub_tb;

    localparam int N          = `XFCP_NUM_PORTS;
    localparam int MEM_WORDS  = 1 << `XFCP_ADDR_W;
    localparam int MAX_CNT    = 8;
    localparam int RAND_REQS  = 60;
    // Two requests per port in tests 1 to 3, four in test 4
    localparam int TOTAL_REQS = 6 * N + 4 + RAND_REQS;
    localparam longint WATCHDOG_NS = longint'(TOTAL_REQS) * (8 + 4 * MAX_CNT) * 8 * 4;

    logic       clk = 1'b0;
    logic       rst_i;
    logic [7:0] in_data_i;
    logic       in_valid_i;
    logic       in_last_i;
    wire        in_ready_o;
    wire  [7:0] out_data_o;
    wire        out_valid_o;
    wire        out_last_o;
    logic       out_ready_i;

    logic [31:0] model_mem [N][MEM_WORDS];
    bit          written   [N][MEM_WORDS];
    logic [7:0]  exp_bytes [N][$];
    int          exp_len   [N][$];
    logic [7:0]  tx_q [$];
    logic [7:0]  rx_q [$];

    int    seed = 22611;
    int    bp_seed = 22611 + 1;
    int    bp_word;
    bit    bp_en = 1'b0;
    int    errors = 0;
    int    checks = 0;
    int    tests = 0;
    int    packets = 0;
    int    err_mark;
    string test_name = "reset";

    xfcp_ram_hub dut (
        .clk(clk),
        .rst_i(rst_i),
        .in_data_i(in_data_i),
        .in_valid_i(in_valid_i),
        .in_last_i(in_last_i),
        .in_ready_o(in_ready_o),
        .out_data_o(out_data_o),
        .out_valid_o(out_valid_o),
        .out_last_o(out_last_o),
        .out_ready_i(out_ready_i)
    );

    bind xfcp_ram_hub xfcp_ram_hub_assertions assertions_inst (
        .clk(clk),
        .rst_i(rst_i),
        .in_valid_i(in_valid_i),
        .in_ready_o(in_ready_o),
        .out_data_o(out_data_o),
        .out_valid_o(out_valid_o),
        .out_last_o(out_last_o),
        .out_ready_i(out_ready_i)
    );

    always #2 clk = ~clk;

    // Host side back-pressure
    always @(negedge clk) begin
        bp_word = $random(bp_seed);
        out_ready_i = bp_en ? bp_word[0] : 1'b1;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    function automatic bit range_written(input int port, input int addr, input int cnt);
        int words;
        words = (cnt == 0) ? 1 : cnt;
        for (int i = 0; i < words; i++) begin
            if (!written[port][(addr + i) % MEM_WORDS]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic put_header(input int port, input logic [7:0] op, input int addr, input int cnt);
        tx_q.push_back(8'(port));
        tx_q.push_back(op);
        tx_q.push_back(8'(addr));
        tx_q.push_back(8'(cnt));
    endtask

    task automatic expect_header(input int port, input logic [7:0] op, input int addr,
                                 input int cnt, input int len);
        exp_len[port].push_back(len);
        exp_bytes[port].push_back(8'(port));
        exp_bytes[port].push_back(op);
        exp_bytes[port].push_back(8'(addr));
        exp_bytes[port].push_back(8'(cnt));
    endtask

    task automatic send_tx();
        for (int i = 0; i < tx_q.size(); i++) begin
            @(negedge clk);
            in_data_i  = tx_q[i];
            in_valid_i = 1'b1;
            in_last_i  = (i == tx_q.size() - 1);
            @(posedge clk);
            while (!in_ready_o) begin
                @(posedge clk);
            end
        end
        tx_q.delete();
    endtask

    task automatic drive_idle();
        @(negedge clk);
        in_valid_i = 1'b0;
        in_last_i  = 1'b0;
    endtask

    task automatic write_req(input int port, input int addr, input int cnt);
        int          words;
        int          a;
        logic [31:0] w;
        words = (cnt == 0) ? 1 : cnt;
        put_header(port, xfcp_proto_pkg::WRITE_REQ, addr, cnt);
        for (int i = 0; i < words; i++) begin
            w = $random(seed);
            // Top nibble tags the port so no two ports share data
            w[31:28] = 4'(port);
            a = (addr + i) % MEM_WORDS;
            model_mem[port][a] = w;
            written[port][a] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                tx_q.push_back(w[8*b +: 8]);
            end
        end
        expect_header(port, xfcp_proto_pkg::WRITE_RESP, addr, cnt, 4);
        send_tx();
    endtask

    task automatic read_req(input int port, input int addr, input int cnt);
        int words;
        int a;
        words = (cnt == 0) ? 1 : cnt;
        put_header(port, xfcp_proto_pkg::READ_REQ, addr, cnt);
        expect_header(port, xfcp_proto_pkg::READ_RESP, addr, cnt, 4 + 4 * words);
        for (int i = 0; i < words; i++) begin
            a = (addr + i) % MEM_WORDS;
            for (int b = 0; b < 4; b++) begin
                exp_bytes[port].push_back(model_mem[port][a][8*b +: 8]);
            end
        end
        send_tx();
    endtask

    // A request that the hub must drop without a response
    task automatic junk_req(input int port, input logic [7:0] op);
        put_header(port, op, rand_below(MEM_WORDS), 1);
        for (int b = 0; b < 4; b++) begin
            tx_q.push_back(8'(rand_below(256)));
        end
        send_tx();
    endtask

    task automatic check_packet();
        int         port;
        int         len;
        logic [7:0] e;
        port = int'(rx_q[0]);
        packets++;
        if (port >= N || exp_len[port].size() == 0) begin
            $display("ERROR %s: unexpected response packet naming port %0d", test_name, port);
            errors++;
            return;
        end
        len = exp_len[port].pop_front();
        checks++;
        if (rx_q.size() != len) begin
            $display("FAILED %s: port %0d length expected %0d actual %0d",
                     test_name, port, len, rx_q.size());
            errors++;
        end
        for (int i = 0; i < len; i++) begin
            e = exp_bytes[port].pop_front();
            if (i < rx_q.size()) begin
                checks++;
                if (rx_q[i] !== e) begin
                    $display("FAILED %s: port %0d byte %0d expected %02h actual %02h",
                             test_name, port, i, e, rx_q[i]);
                    errors++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_i && out_valid_o && out_ready_i) begin
            rx_q.push_back(out_data_o);
            if (out_last_o) begin
                check_packet();
                rx_q.delete();
            end
        end
    end

    task automatic wait_responses();
        bit busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = 1'b0;
            for (int p = 0; p < N; p++) begin
                if (exp_len[p].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        wait_responses();
        tests++;
        if (errors == err_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - err_mark);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: responses still outstanding after %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        int a;
        int c;
        int p;
        rst_i       = 1'b1;
        // A byte offered during reset must not be taken
        in_data_i   = 8'h5a;
        in_valid_i  = 1'b1;
        in_last_i   = 1'b0;
        out_ready_i = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_i      = 1'b0;
        in_valid_i = 1'b0;

        start_test("single_write_read");
        for (int i = 0; i < N; i++) begin
            a = rand_below(MEM_WORDS);
            write_req(i, a, 1);
            drive_idle();
            read_req(i, a, 1);
            drive_idle();
        end
        end_test();

        // Start close enough to the top that the burst wraps
        start_test("burst_wrap");
        for (int i = 0; i < N; i++) begin
            c = 2 + rand_below(MAX_CNT - 1);
            a = MEM_WORDS - 1 - rand_below(c - 1);
            write_req(i, a, c);
            drive_idle();
            read_req(i, a, c);
            drive_idle();
        end
        end_test();

        start_test("port_isolation");
        a = rand_below(MEM_WORDS);
        for (int i = 0; i < N; i++) begin
            write_req(i, a, 1);
        end
        for (int i = 0; i < N; i++) begin
            read_req(i, a, 1);
        end
        drive_idle();
        end_test();

        start_test("dropped_packets");
        p = rand_below(N);
        a = rand_below(MEM_WORDS);
        junk_req(N + rand_below(256 - N), xfcp_proto_pkg::WRITE_REQ);
        write_req(p, a, 1);
        junk_req(p, 8'h55);
        read_req(p, a, 1);
        drive_idle();
        wait_responses();
        // Quiet period to catch a stray response
        repeat (4 * (8 + 4 * MAX_CNT)) @(negedge clk);
        end_test();

        start_test("random_backpressure");
        bp_en <= 1'b1;
        for (int i = 0; i < RAND_REQS; i++) begin
            p = rand_below(N);
            a = rand_below(MEM_WORDS);
            c = rand_below(5);
            if (rand_below(2) == 1 && range_written(p, a, c)) begin
                read_req(p, a, c);
            end else begin
                write_req(p, a, c);
            end
        end
        drive_idle();
        end_test();
        bp_en <= 1'b0;

        // Any stray packet finishes here and is flagged by the monitor
        repeat (8 + 4 * MAX_CNT) @(negedge clk);
        if (rx_q.size() != 0 || out_valid_o) begin
            $display("response stream still busy after every expected packet arrived");
            errors++;
        end
        $display("tests %0d, packets %0d, checks %0d, errors %0d",
                 tests, packets, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/xfcp_proto_pkg.sv
rtl/xfcp_mem_pkg.sv
rtl/xfcp_cmd_router.sv
rtl/xfcp_ram_endpoint.sv
rtl/xfcp_resp_arbiter.sv
rtl/xfcp_ram_hub.sv
verif/xfcp_ram_hub_assertions.sv
verif/xfcp_ram_hub_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= xfcp_ram_hub_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard rtl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
